//--- test/bridge_golden.txt
# T name mode reps, then S awaddr wdata wstrb / L araddr / B awaddr wdata wstrb araddr
# E expected noc2 flit in hex; request and flit lines of a test repeat reps times
T single_store plain 1
S 0010000040 0123456789abcdef ff
E 0000040880c6c000
E 00100000408000ff
E 00040c1400000000
E 0123456789abcdef
T single_load plain 1
L 00200000a8
E 0000040880868000
E 00200000a8a00000
E 00040c1400000000
T mixed_order stalled 1
L 00200000a8
B 8000001008 deadbeefcafef00d 0f 0000003ff8
E 0000040880868000
E 00200000a8a00000
E 00040c1400000000
E 0000040880c6c000
E 800000100880000f
E 00040c1400000000
E deadbeefcafef00d
E 0000040880868000
E 0000003ff8a00000
E 00040c1400000000
T fill_queues hold 17
S 0000000100 5555aaaa5555aaaa 3c
E 0000040880c6c000
E 000000010080003c
E 00040c1400000000
E 5555aaaa5555aaaa

//--- src.f
+incdir+rtl
rtl/bridge_pkg.sv
rtl/sync_fifo.sv
rtl/axi_request_capture.sv
rtl/noc_flit_builder.sv
rtl/axilite_noc_bridge.sv
test/tb_axilite_noc_bridge.sv

//--- Makefile
# Verilator build and run of the AXI-lite to NoC bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_axilite_noc_bridge
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# pass or fail comes from the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_axilite_noc_bridge.sv
`default_nettype none

module tb_axilite_noc_bridge;

    import bridge_pkg::*;

    logic       clk = 1'b0;
    logic       rst;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    chipid_t    dest_chipid;
    xy_t        dest_x;
    xy_t        dest_y;
    fbits_t     dest_fbits;
    chipid_t    src_chipid;
    xy_t        src_x;
    xy_t        src_y;
    fbits_t     src_fbits;
    logic       noc2_valid;
    flit_t      noc2_data;
    logic       noc2_ready;

    // golden tests flattened into queues
    string  t_name[$];
    string  t_mode[$];
    int     t_reps[$];
    int     t_req_first[$];
    int     t_nreq[$];
    int     t_nacc[$];   // accepted requests per repetition
    int     t_exp_first[$];
    int     t_nexp[$];
    string  rq_kind[$];
    addr_t  rq_addr[$];
    data_t  rq_data[$];
    strb_t  rq_strb[$];
    addr_t  rq_laddr[$];
    flit_t  ex_flit[$];

    flit_t       got[$];  // flits seen on noc2
    int          accepted;
    int          errors;
    int          failed_tests;
    int          wd_cycles;
    bit          hold_ready;
    bit          stalled;
    integer      seed = 32'h475f7b7a;
    logic [31:0] rnd;

    axilite_noc_bridge uut (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .dest_chipid(dest_chipid), .dest_x(dest_x), .dest_y(dest_y), .dest_fbits(dest_fbits),
        .src_chipid(src_chipid), .src_x(src_x), .src_y(src_y), .src_fbits(src_fbits),
        .noc2_valid(noc2_valid), .noc2_data(noc2_data), .noc2_ready(noc2_ready)
    );

    always #50 clk = ~clk;

    // noc2 sink with random back-pressure when stalled
    always @(negedge clk) begin
        rnd = $random(seed);
        if (hold_ready) noc2_ready = 1'b0;
        else if (stalled) noc2_ready = rnd[0];
        else noc2_ready = 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && noc2_valid && noc2_ready) got.push_back(noc2_data);
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the bridge did not finish within %0d cycles", wd_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_flit(input flit_t exp, input flit_t act, input string name);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_ready(input logic exp, input logic act, input string name);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_count(input int exp, input int act, input string name);
        if (exp != act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic load_golden(output bit ok);
        int    fd;
        int    r;
        int    last;
        int    reps;
        string tok;
        string nm;
        string md;
        string line;
        addr_t a;
        addr_t la;
        data_t d;
        strb_t s;
        flit_t f;
        ok = 1'b0;
        fd = $fopen("test/bridge_golden.txt", "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                last = t_name.size() - 1;
                if (tok == "#") begin
                    r = $fgets(line, fd);  // column notes
                end else if (tok == "T") begin
                    r = $fscanf(fd, "%s %s %d", nm, md, reps);
                    t_name.push_back(nm);
                    t_mode.push_back(md);
                    t_reps.push_back(reps);
                    t_req_first.push_back(rq_kind.size());
                    t_exp_first.push_back(ex_flit.size());
                    t_nreq.push_back(0);
                    t_nacc.push_back(0);
                    t_nexp.push_back(0);
                end else if (tok == "E") begin
                    r = $fscanf(fd, "%h", f);
                    ex_flit.push_back(f);
                    t_nexp[last] = t_nexp[last] + 1;
                end else begin
                    a = '0;
                    d = '0;
                    s = '0;
                    la = '0;
                    if (tok == "L") r = $fscanf(fd, "%h", la);
                    else if (tok == "S") r = $fscanf(fd, "%h %h %h", a, d, s);
                    else r = $fscanf(fd, "%h %h %h %h", a, d, s, la);
                    rq_kind.push_back(tok);
                    rq_addr.push_back(a);
                    rq_data.push_back(d);
                    rq_strb.push_back(s);
                    rq_laddr.push_back(la);
                    t_nreq[last] = t_nreq[last] + 1;
                    t_nacc[last] = t_nacc[last] + ((tok == "B") ? 2 : 1);
                end
            end
            $fclose(fd);
            ok = (t_name.size() > 0);
        end
    endtask

    task automatic apply_reset(input string nm);
        rst = 1'b1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
        hold_ready = 1'b0;
        stalled = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_ready(1'b0, noc2_valid, {nm, " noc2_valid after reset"});
        check_ready(1'b1, awready, {nm, " awready after reset"});
        check_ready(1'b1, wready, {nm, " wready after reset"});
        check_ready(1'b1, arready, {nm, " arready after reset"});
    endtask

    // S store, L load, B store and load offered in the same cycle
    task automatic send_request(input string kind, input addr_t a, input data_t d,
                                input strb_t s, input addr_t la);
        logic st_pend;
        logic ld_pend;
        logic st_acc;
        logic ld_acc;
        st_pend = (kind == "S") || (kind == "B");
        ld_pend = (kind == "L") || (kind == "B");
        awaddr = a;
        wdata = d;
        wstrb = s;
        araddr = la;
        while (st_pend || ld_pend) begin
            awvalid = st_pend;
            wvalid = st_pend;
            arvalid = ld_pend;
            #1;
            st_acc = st_pend && awready && wready;
            ld_acc = ld_pend && arready;
            @(posedge clk);
            if (st_acc) st_pend = 1'b0;
            if (ld_acc) ld_pend = 1'b0;
            accepted = accepted + int'(st_acc) + int'(ld_acc);
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
    endtask

    // store held on the bus for a few cycles while noc2 is blocked
    task automatic offer_store_held(input addr_t a, input data_t d, input strb_t s,
                                    input int cycles);
        awaddr = a;
        wdata = d;
        wstrb = s;
        awvalid = 1'b1;
        wvalid = 1'b1;
        repeat (cycles) begin
            #1;
            if (awready && wready) accepted = accepted + 1;
            @(posedge clk);
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
    endtask

    task automatic run_test(input int t);
        flit_t exp_q[$];
        string nm;
        int    err0;
        int    k;
        nm = t_name[t];
        err0 = errors;
        apply_reset(nm);
        got.delete();
        accepted = 0;
        hold_ready = (t_mode[t] == "hold");
        stalled = (t_mode[t] == "stalled");
        for (int i = 0; i < t_reps[t]; i++) begin
            for (int j = 0; j < t_nexp[t]; j++) exp_q.push_back(ex_flit[t_exp_first[t] + j]);
        end
        for (int i = 0; i < t_reps[t]; i++) begin
            if (hold_ready && i == t_reps[t] - 1) begin
                // queues full so the last store must be refused
                k = t_req_first[t];
                offer_store_held(rq_addr[k], rq_data[k], rq_strb[k], 4);
                check_count(i * t_nacc[t], accepted, {nm, " accepted while noc2 held"});
                check_ready(1'b0, awready, {nm, " awready with full queues"});
                check_ready(1'b0, wready, {nm, " wready with full queues"});
                hold_ready = 1'b0;
            end
            for (int j = 0; j < t_nreq[t]; j++) begin
                k = t_req_first[t] + j;
                send_request(rq_kind[k], rq_addr[k], rq_data[k], rq_strb[k], rq_laddr[k]);
            end
        end
        while (got.size() < exp_q.size()) @(negedge clk);
        repeat (20) @(negedge clk);  // catch extra flits
        check_count(t_reps[t] * t_nacc[t], accepted, {nm, " accepted requests"});
        check_count(exp_q.size(), got.size(), {nm, " flit count"});
        for (int i = 0; i < exp_q.size() && i < got.size(); i++) begin
            check_flit(exp_q[i], got[i], $sformatf("%s flit %0d", nm, i));
        end
        if (errors == err0) begin
            $display("test %s (%s): ok", nm, t_mode[t]);
        end else begin
            $display("test %s (%s): %0d errors", nm, t_mode[t], errors - err0);
            failed_tests = failed_tests + 1;
        end
    endtask

    initial begin
        bit ok;
        int total;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        noc2_ready = 1'b1;
        dest_chipid = 14'd0;
        dest_x = 8'd1;
        dest_y = 8'd2;
        dest_fbits = 4'd2;
        src_chipid = 14'd1;
        src_x = 8'd3;
        src_y = 8'd5;
        src_fbits = 4'd0;
        errors = 0;
        failed_tests = 0;
        wd_cycles = 0;
        hold_ready = 1'b0;
        stalled = 1'b0;
        load_golden(ok);
        if (!ok) begin
            $display("could not read any test from test/bridge_golden.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            total = 0;
            foreach (t_name[t]) total = total + t_nexp[t] * t_reps[t];
            wd_cycles = total * 40 + 2000;
            foreach (t_name[t]) run_test(t);
            $display("tests %0d, failed %0d, errors %0d", t_name.size(), failed_tests, errors);
            if (errors == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- rtl/axilite_noc_bridge.sv
`default_nettype none

module axilite_noc_bridge (
    input  wire                      clk,
    input  wire                      rst,
    // axi-lite write
    input  wire bridge_pkg::addr_t   awaddr,
    input  wire                      awvalid,
    output logic                     awready,
    input  wire bridge_pkg::data_t   wdata,
    input  wire bridge_pkg::strb_t   wstrb,
    input  wire                      wvalid,
    output logic                     wready,
    // axi-lite read address
    input  wire bridge_pkg::addr_t   araddr,
    input  wire                      arvalid,
    output logic                     arready,
    // coordinates
    input  wire bridge_pkg::chipid_t dest_chipid,
    input  wire bridge_pkg::xy_t     dest_x,
    input  wire bridge_pkg::xy_t     dest_y,
    input  wire bridge_pkg::fbits_t  dest_fbits,
    input  wire bridge_pkg::chipid_t src_chipid,
    input  wire bridge_pkg::xy_t     src_x,
    input  wire bridge_pkg::xy_t     src_y,
    input  wire bridge_pkg::fbits_t  src_fbits,
    // noc2
    output logic                     noc2_valid,
    output bridge_pkg::flit_t        noc2_data,
    input  wire                      noc2_ready
);

    import bridge_pkg::*;

    req_kind_t    head_kind;
    logic         kind_valid;
    store_entry_t store_head;
    addr_t        load_head;
    logic         release_store;
    logic         release_load;

    axi_request_capture u_capture (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .head_kind(head_kind), .kind_valid(kind_valid),
        .store_head(store_head), .load_head(load_head),
        .release_store(release_store), .release_load(release_load)
    );

    noc_flit_builder u_builder (
        .clk(clk), .rst(rst),
        .head_kind(head_kind), .kind_valid(kind_valid),
        .store_head(store_head), .load_head(load_head),
        .release_store(release_store), .release_load(release_load),
        .dest_chipid(dest_chipid), .dest_x(dest_x), .dest_y(dest_y), .dest_fbits(dest_fbits),
        .src_chipid(src_chipid), .src_x(src_x), .src_y(src_y), .src_fbits(src_fbits),
        .noc2_valid(noc2_valid), .noc2_data(noc2_data), .noc2_ready(noc2_ready)
    );

endmodule

`default_nettype wire

//--- rtl/noc_flit_builder.sv
`default_nettype none

`include "bridge_macros.svh"

module noc_flit_builder (
    input  wire                          clk,
    input  wire                          rst,
    // queue heads from capture
    input  wire bridge_pkg::req_kind_t   head_kind,
    input  wire                          kind_valid,
    input  wire bridge_pkg::store_entry_t store_head,
    input  wire bridge_pkg::addr_t       load_head,
    output logic                         release_store,
    output logic                         release_load,
    // node coordinates
    input  wire bridge_pkg::chipid_t     dest_chipid,
    input  wire bridge_pkg::xy_t         dest_x,
    input  wire bridge_pkg::xy_t         dest_y,
    input  wire bridge_pkg::fbits_t      dest_fbits,
    input  wire bridge_pkg::chipid_t     src_chipid,
    input  wire bridge_pkg::xy_t         src_x,
    input  wire bridge_pkg::xy_t         src_y,
    input  wire bridge_pkg::fbits_t      src_fbits,
    // noc2 output
    output logic                         noc2_valid,
    output bridge_pkg::flit_t            noc2_data,
    input  wire                          noc2_ready
);

    import bridge_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_DATA
    } state_t;

    state_t      state;
    logic [1:0]  flit_cnt;     // header flit index
    logic        is_store;
    logic        flit_fire;
    logic        last_header;
    addr_t       head_addr;
    logic [7:0]  msg_length;
    logic [7:0]  msg_type;
    logic [2:0]  msg_size;
    strb_t       msg_mask;
    flit_t       flit;

    assign is_store    = (head_kind == KIND_STORE);
    assign flit_fire   = noc2_valid && noc2_ready;
    assign last_header = (flit_cnt == 2'(`BRIDGE_HDR_FLITS - 1));

    // header fields picked by the head kind
    assign head_addr  = is_store ? store_head.addr : load_head;
    assign msg_length = is_store ? `STORE_MSG_LEN : `LOAD_MSG_LEN;
    assign msg_type   = is_store ? `MSG_TYPE_STORE_REQ : `MSG_TYPE_LOAD_REQ;
    assign msg_size   = is_store ? `MSG_DATA_SIZE_8B : `MSG_DATA_SIZE_16B;
    assign msg_mask   = is_store ? store_head.strb : '0;  // loads carry no mask

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            flit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    flit_cnt <= '0;
                    if (kind_valid) state <= ST_HEADER;
                end
                ST_HEADER: begin
                    if (flit_fire) begin
                        if (last_header) begin
                            flit_cnt <= '0;
                            state    <= is_store ? ST_DATA : ST_IDLE;
                        end else begin
                            flit_cnt <= flit_cnt + 2'd1;
                        end
                    end
                end
                ST_DATA: begin
                    if (flit_fire) state <= ST_IDLE;  // single data flit
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // flit contents, stable while the heads are stable
    always_comb begin
        flit = '0;
        case (state)
            ST_HEADER: begin
                case (flit_cnt)
                    2'd0: begin
                        flit[`HDR_CHIPID] = dest_chipid;
                        flit[`HDR_X]      = dest_x;
                        flit[`HDR_Y]      = dest_y;
                        flit[`HDR_FBITS]  = dest_fbits;
                        flit[`HDR_LENGTH] = msg_length;
                        flit[`HDR_TYPE]   = msg_type;
                        flit[`HDR_MSHRID] = '0;  // no outstanding-miss tracking
                    end
                    2'd1: begin
                        flit[`HDR_ADDR]      = head_addr;
                        flit[`HDR_DATA_SIZE] = msg_size;
                        flit[`HDR_MASK]      = msg_mask;
                    end
                    default: begin
                        flit[`HDR_CHIPID] = src_chipid;
                        flit[`HDR_X]      = src_x;
                        flit[`HDR_Y]      = src_y;
                        flit[`HDR_FBITS]  = src_fbits;
                    end
                endcase
            end
            ST_DATA: flit = store_head.data;
            default: flit = '0;
        endcase
    end

    assign noc2_valid = (state != ST_IDLE);
    assign noc2_data  = flit;

    // pop queues as the last flit leaves
    assign release_store = (state == ST_DATA) && flit_fire;
    assign release_load  = (state == ST_HEADER) && last_header && !is_store && flit_fire;

endmodule

`default_nettype wire

//--- rtl/axi_request_capture.sv
`default_nettype none

module axi_request_capture (
    input  wire                      clk,
    input  wire                      rst,
    // write address and data, taken together as one store
    input  wire bridge_pkg::addr_t   awaddr,
    input  wire                      awvalid,
    output logic                     awready,
    input  wire bridge_pkg::data_t   wdata,
    input  wire bridge_pkg::strb_t   wstrb,
    input  wire                      wvalid,
    output logic                     wready,
    // read address
    input  wire bridge_pkg::addr_t   araddr,
    input  wire                      arvalid,
    output logic                     arready,
    // queue heads toward the builder
    output bridge_pkg::req_kind_t    head_kind,
    output logic                     kind_valid,
    output bridge_pkg::store_entry_t store_head,
    output bridge_pkg::addr_t        load_head,
    input  wire                      release_store,
    input  wire                      release_load
);

    import bridge_pkg::*;

    logic         kind_full;
    logic         kind_empty;
    logic         store_full;
    logic         load_full;
    logic         store_ok;
    logic         store_offer;
    logic         store_accept;
    logic         load_accept;
    logic         kind_push;
    req_kind_t    kind_in;
    store_entry_t store_in;

    assign store_ok    = !store_full && !kind_full;
    assign store_offer = awvalid && wvalid;
    assign awready     = store_ok;  // aw and w share one ready
    assign wready      = store_ok;
    // store wins when both are offered
    assign arready     = !load_full && !kind_full && !store_offer;

    assign store_accept = store_offer && store_ok;
    assign load_accept  = arvalid && arready;
    assign kind_push    = store_accept || load_accept;
    assign kind_in      = store_accept ? KIND_STORE : KIND_LOAD;
    assign store_in     = '{addr: awaddr, data: wdata, strb: wstrb};
    assign kind_valid   = !kind_empty;

    // arrival order of all requests
    sync_fifo #(.payload_t(req_kind_t)) kind_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (kind_push),
        .wr_data (kind_in),
        .rd_en   (release_store || release_load),
        .rd_data (head_kind),
        .empty   (kind_empty),
        .full    (kind_full)
    );

    sync_fifo #(.payload_t(store_entry_t)) store_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (store_accept),
        .wr_data (store_in),
        .rd_en   (release_store),
        .rd_data (store_head),
        .empty   (),
        .full    (store_full)
    );

    sync_fifo #(.payload_t(addr_t)) load_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (load_accept),
        .wr_data (araddr),
        .rd_en   (release_load),
        .rd_data (load_head),
        .empty   (),
        .full    (load_full)
    );

endmodule

`default_nettype wire

//--- rtl/sync_fifo.sv
`default_nettype none

`include "bridge_macros.svh"

module sync_fifo #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      wr_en,
    input  payload_t wr_data,
    input  wire      rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam int DEPTH = `BRIDGE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;  // one extra bit to hold DEPTH
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && !full;   // drop writes when full
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd) count <= count + 1'b1;
            else if (do_rd && !do_wr) count <= count - 1'b1;
        end
    end

    assign rd_data = mem[rd_ptr];  // head always on the output
    assign empty   = (count == '0);
    assign full    = (count == (PTR_W + 1)'(DEPTH));

endmodule

`default_nettype wire

//--- rtl/bridge_pkg.sv
`default_nettype none

`include "bridge_macros.svh"

package bridge_pkg;

    // order of requests in the type queue
    typedef enum logic [0:0] {
        KIND_STORE = 1'b0,
        KIND_LOAD  = 1'b1
    } req_kind_t;

    typedef logic [`BRIDGE_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`BRIDGE_DATA_WIDTH-1:0]   data_t;
    typedef logic [`BRIDGE_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [`BRIDGE_DATA_WIDTH-1:0]   flit_t;

    // one queued store, 112 bits
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } store_entry_t;

    // noc coordinates
    typedef logic [`BRIDGE_CHIPID_WIDTH-1:0] chipid_t;
    typedef logic [`BRIDGE_XY_WIDTH-1:0]     xy_t;
    typedef logic [`BRIDGE_FBITS_WIDTH-1:0]  fbits_t;

endpackage

`default_nettype wire

//--- rtl/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

`define BRIDGE_ADDR_WIDTH   40
`define BRIDGE_DATA_WIDTH   64  // axi data and flit width
`define BRIDGE_FIFO_DEPTH   16
`define BRIDGE_HDR_FLITS    3   // header flits per packet

// node coordinates
`define BRIDGE_CHIPID_WIDTH 14
`define BRIDGE_XY_WIDTH     8
`define BRIDGE_FBITS_WIDTH  4

// message codes
`define MSG_TYPE_STORE_REQ  8'd27
`define MSG_TYPE_LOAD_REQ   8'd26
`define MSG_DATA_SIZE_8B    3'd4
`define MSG_DATA_SIZE_16B   3'd5
`define STORE_MSG_LEN       8'd3  // flits after header 1
`define LOAD_MSG_LEN        8'd2

// header 1 and 3 share the coordinate positions
`define HDR_CHIPID    63:50
`define HDR_X         49:42
`define HDR_Y         41:34
`define HDR_FBITS     33:30
`define HDR_LENGTH    29:22
`define HDR_TYPE      21:14
`define HDR_MSHRID    13:6
`define HDR_ADDR      63:24   // header 2
`define HDR_DATA_SIZE 23:21
`define HDR_MASK      7:0

`endif
